// File: build.f
+incdir+include
verilog/exec_isa_pkg.sv
verilog/exec_state_pkg.sv
verilog/exec_alu_if.sv
verilog/exec_alu.sv
verilog/exec_branch_cond.sv
verilog/exec_ctrl_regs.sv
verilog/exec_stage.sv
dv/exec_stage_tb.sv

// File: dv/exec_stage_tb.sv
`include "exec_cfg.svh"

module exec_stage_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int XLEN = `EXEC_XLEN;
	localparam int VBW = `EXEC_XLEN - `EXEC_VEC_LSB;

	// one instruction per row checked one clock later
	typedef struct {
		logic                        valid;
		exec_isa_pkg::alu_opc_e      opc;
		exec_isa_pkg::op1_sel_e      op1_sel;
		exec_isa_pkg::instr_class_e  cls;
		exec_isa_pkg::branch_cc_e    cc;
		exec_state_pkg::cr_idx_e     cr_sel;
		exec_state_pkg::cr_idx_e     dbg_sel;
		logic [3:0]                  rd_sel;
		logic                        upd_rd;
		logic                        op2_rb;
		logic                        is_call;
		logic                        upd_carry;
		logic                        upd_flags;
		logic                        write_cr;
		logic                        is_swi;
		logic                        is_rfe;
		logic                        exc;
		logic                        mem_load;
		logic                        mem_store;
		logic [1:0]                  mem_width;
		logic                        dbg_we;
		logic [XLEN-1:0]             ra;
		logic [XLEN-1:0]             rb;
		logic [XLEN-1:0]             imm;
		logic [XLEN-1:0]             pc4;
		logic [XLEN-1:0]             fault;
		logic [XLEN-1:0]             dbg_val;
		logic                        chk_alu;
		logic [XLEN-1:0]             exp_alu;
		logic [XLEN-1:0]             exp_wr;
		logic                        exp_br;
		logic                        chk_dbg;
		logic [XLEN-1:0]             exp_dbg;
		logic                        chk_irq;
		logic                        exp_irq;
		logic                        chk_vb;
		logic [VBW-1:0]              exp_vb;
		logic                        chk_mem;
		logic [XLEN-1:0]             exp_mar;
		logic [XLEN-1:0]             exp_mdr;
	} row_t;

	logic                         clk;
	logic                         rst;
	logic                         i_valid;
	logic [XLEN-1:0]              i_ra;
	logic [XLEN-1:0]              i_rb;
	logic [XLEN-1:0]              i_imm;
	logic [XLEN-1:0]              i_pc_plus_4;
	logic [3:0]                   i_rd_sel;
	logic                         i_update_rd;
	exec_isa_pkg::alu_opc_e       i_alu_opc;
	exec_isa_pkg::op1_sel_e       i_op1_sel;
	logic                         i_op2_rb;
	logic                         i_mem_load;
	logic                         i_mem_store;
	logic [1:0]                   i_mem_width;
	exec_isa_pkg::branch_cc_e     i_branch_cc;
	exec_isa_pkg::instr_class_e   i_instr_class;
	logic                         i_is_call;
	logic                         i_update_carry;
	logic                         i_update_flags;
	exec_state_pkg::cr_idx_e      i_cr_sel;
	logic                         i_write_cr;
	logic                         i_is_swi;
	logic                         i_is_rfe;
	logic                         i_exception_start;
	logic [XLEN-1:0]              i_fault_address;
	exec_state_pkg::cr_idx_e      i_dbg_cr_sel;
	logic                         i_dbg_cr_wr_en;
	logic [XLEN-1:0]              i_dbg_cr_wr_val;
	logic                         o_valid;
	logic                         o_branch_taken;
	logic [XLEN-1:0]              o_alu_out;
	logic [XLEN-1:0]              o_wr_val;
	logic                         o_wr_result;
	logic [3:0]                   o_rd_sel;
	logic                         o_mem_load;
	logic                         o_mem_store;
	logic [1:0]                   o_mem_width;
	logic [XLEN-1:0]              o_mar;
	logic [XLEN-1:0]              o_mdr;
	logic [XLEN-1:0]              o_dbg_cr_val;
	logic [VBW-1:0]               o_vector_base;
	logic                         o_irqs_enabled;

	row_t rows[$];
	int   cycles;
	int   cycle_limit;

	exec_stage dut_i (.*);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: table not finished after %0d cycles", cycles);
			$display("Testbench failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic report_mismatch(input string msg);
		$display("ERR %0t ns: %s", $time, msg);
		$display("Testbench failed");
		$fatal(1, "stopping at the first mismatch");
	endtask

	function automatic row_t blank_row();
		row_t r;
		r.valid = 1'b0;
		r.opc = exec_isa_pkg::ALU_COPYA;
		r.op1_sel = exec_isa_pkg::OP1_RA;
		r.cls = exec_isa_pkg::CLASS_MISC;
		r.cc = exec_isa_pkg::CC_NEVER;
		r.cr_sel = exec_state_pkg::CR_VBASE;
		r.dbg_sel = exec_state_pkg::CR_PSR;
		r.rd_sel = 4'd0;
		r.upd_rd = 1'b0;
		r.op2_rb = 1'b1;
		r.is_call = 1'b0;
		r.upd_carry = 1'b0;
		r.upd_flags = 1'b0;
		r.write_cr = 1'b0;
		r.is_swi = 1'b0;
		r.is_rfe = 1'b0;
		r.exc = 1'b0;
		r.mem_load = 1'b0;
		r.mem_store = 1'b0;
		r.mem_width = 2'd2;
		r.dbg_we = 1'b0;
		r.ra = '0;
		r.rb = '0;
		r.imm = '0;
		r.pc4 = '0;
		r.fault = '0;
		r.dbg_val = '0;
		r.chk_alu = 1'b0;
		r.exp_alu = '0;
		r.exp_wr = '0;
		r.exp_br = 1'b0;
		r.chk_dbg = 1'b0;
		r.exp_dbg = '0;
		r.chk_irq = 1'b0;
		r.exp_irq = 1'b0;
		r.chk_vb = 1'b0;
		r.exp_vb = '0;
		r.chk_mem = 1'b0;
		r.exp_mar = '0;
		r.exp_mdr = '0;
		return r;
	endfunction

	function automatic row_t alu_row(input exec_isa_pkg::alu_opc_e opc,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [XLEN-1:0] exp);
		row_t r;
		r = blank_row();
		r.valid = 1'b1;
		r.cls = exec_isa_pkg::CLASS_ARITH;
		r.opc = opc;
		r.ra = a;
		r.rb = b;
		r.rd_sel = 4'($urandom());
		r.upd_rd = 1'b1;
		r.chk_alu = 1'b1;
		r.exp_alu = exp;
		r.exp_wr = exp;
		return r;
	endfunction

	// branch target is pc plus immediate
	function automatic row_t branch_row(input exec_isa_pkg::branch_cc_e cc, input logic taken);
		row_t r;
		r = blank_row();
		r.valid = 1'b1;
		r.cls = exec_isa_pkg::CLASS_BRANCH;
		r.cc = cc;
		r.opc = exec_isa_pkg::ALU_ADD;
		r.op1_sel = exec_isa_pkg::OP1_PC;
		r.op2_rb = 1'b0;
		r.pc4 = $urandom() & ~32'h3;
		r.imm = $urandom();
		r.chk_alu = 1'b1;
		r.exp_alu = r.pc4 + r.imm;
		r.exp_wr = r.exp_alu;
		r.exp_br = taken;
		return r;
	endfunction

	// outcome of a branch after comparing a with b
	function automatic logic expect_taken(input exec_isa_pkg::branch_cc_e cc,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		case (cc)
		exec_isa_pkg::CC_NE:     return a != b;
		exec_isa_pkg::CC_EQ:     return a == b;
		exec_isa_pkg::CC_GT:     return a > b;
		exec_isa_pkg::CC_LT:     return a < b;
		exec_isa_pkg::CC_GTS:    return $signed(a) > $signed(b);
		exec_isa_pkg::CC_LTS:    return $signed(a) < $signed(b);
		exec_isa_pkg::CC_ALWAYS: return 1'b1;
		exec_isa_pkg::CC_GTE:    return a >= b;
		exec_isa_pkg::CC_GTES:   return $signed(a) >= $signed(b);
		exec_isa_pkg::CC_LTE:    return a <= b;
		exec_isa_pkg::CC_LTES:   return $signed(a) <= $signed(b);
		default:                 return 1'b0;
		endcase
	endfunction

	task automatic build_table();
		row_t            r;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] v;
		logic [XLEN-1:0] f;
		logic [XLEN-1:0] vbase_full;
		logic [4:0]      sh;
		logic [XLEN-1:0] cmp_a [5];
		logic [XLEN-1:0] cmp_b [5];

		a = $urandom();
		b = $urandom();
		sh = b[4:0];
		rows.push_back(alu_row(exec_isa_pkg::ALU_ADD, a, b, a + b));
		rows.push_back(alu_row(exec_isa_pkg::ALU_SUB, a, b, a - b));
		rows.push_back(alu_row(exec_isa_pkg::ALU_MUL, a, b, a * b));
		rows.push_back(alu_row(exec_isa_pkg::ALU_LSL, a, b, a << sh));
		rows.push_back(alu_row(exec_isa_pkg::ALU_LSR, a, b, a >> sh));
		rows.push_back(alu_row(exec_isa_pkg::ALU_ASR, a, b, $signed(a) >>> sh));
		rows.push_back(alu_row(exec_isa_pkg::ALU_AND, a, b, a & b));
		rows.push_back(alu_row(exec_isa_pkg::ALU_OR, a, b, a | b));
		rows.push_back(alu_row(exec_isa_pkg::ALU_XOR, a, b, a ^ b));
		rows.push_back(alu_row(exec_isa_pkg::ALU_BIC, a, b, a & ~(32'd1 << sh)));
		rows.push_back(alu_row(exec_isa_pkg::ALU_BST, a, b, a | (32'd1 << sh)));
		rows.push_back(alu_row(exec_isa_pkg::ALU_COPYA, a, b, a));
		rows.push_back(alu_row(exec_isa_pkg::ALU_COPYB, a, b, b));
		rows.push_back(alu_row(exec_isa_pkg::ALU_MOVHI, a, b, a | {16'h0, b[15:0]}));

		// both top bits set so the add carries out
		a = $urandom() | 32'h8000_0000;
		b = $urandom() | 32'h8000_0000;
		r = alu_row(exec_isa_pkg::ALU_ADD, a, b, a + b);
		r.upd_carry = 1'b1;
		rows.push_back(r);
		a = $urandom();
		b = $urandom();
		rows.push_back(alu_row(exec_isa_pkg::ALU_ADDC, a, b, a + b + 1));
		rows.push_back(alu_row(exec_isa_pkg::ALU_SUBC, a, b, a - b - 1));
		r = alu_row(exec_isa_pkg::ALU_ADD, 32'd1, 32'd1, 32'd2);
		r.upd_carry = 1'b1;
		rows.push_back(r);
		rows.push_back(alu_row(exec_isa_pkg::ALU_ADDC, a, b, a + b));

		cmp_a = '{32'd5, 32'd9, 32'd7, 32'h8000_0000, 32'd1};
		cmp_b = '{32'd9, 32'd5, 32'd7, 32'd1, 32'hffff_ffff};
		for (int k = 0; k < 5; k++) begin
			r = alu_row(exec_isa_pkg::ALU_CMP, cmp_a[k], cmp_b[k], cmp_a[k] - cmp_b[k]);
			r.upd_flags = 1'b1;
			r.upd_carry = 1'b1;
			rows.push_back(r);
			for (int c = 0; c < 12; c++)
				rows.push_back(branch_row(exec_isa_pkg::branch_cc_e'(c),
					expect_taken(exec_isa_pkg::branch_cc_e'(c), cmp_a[k], cmp_b[k])));
		end
		r = branch_row(exec_isa_pkg::CC_ALWAYS, 1'b0);
		r.valid = 1'b0;
		r.chk_alu = 1'b0;
		rows.push_back(r);

		// instruction write then debug write and GCR read
		a = $urandom();
		r = alu_row(exec_isa_pkg::ALU_COPYA, a, 32'd0, a);
		r.cls = exec_isa_pkg::CLASS_MISC;
		r.write_cr = 1'b1;
		r.cr_sel = exec_state_pkg::CR_DFAULT_ADDR;
		r.dbg_sel = exec_state_pkg::CR_DFAULT_ADDR;
		r.chk_dbg = 1'b1;
		r.exp_dbg = a;
		rows.push_back(r);
		f = $urandom();
		r = blank_row();
		r.dbg_we = 1'b1;
		r.dbg_sel = exec_state_pkg::CR_FAULT_ADDR;
		r.dbg_val = f;
		r.chk_dbg = 1'b1;
		r.exp_dbg = f;
		rows.push_back(r);
		r = alu_row(exec_isa_pkg::ALU_GCR, 32'd0, 32'd0, f);
		r.cr_sel = exec_state_pkg::CR_FAULT_ADDR;
		rows.push_back(r);
		r = alu_row(exec_isa_pkg::ALU_GCR, 32'd0, 32'd0, a);
		r.cr_sel = exec_state_pkg::CR_DFAULT_ADDR;
		rows.push_back(r);

		v = $urandom();
		r = blank_row();
		r.dbg_we = 1'b1;
		r.dbg_sel = exec_state_pkg::CR_VBASE;
		r.dbg_val = v;
		r.chk_dbg = 1'b1;
		r.exp_dbg = v & ~((32'd1 << `EXEC_VEC_LSB) - 1);
		r.chk_vb = 1'b1;
		r.exp_vb = v[XLEN-1:`EXEC_VEC_LSB];
		rows.push_back(r);
		v = $urandom();
		vbase_full = v & ~((32'd1 << `EXEC_VEC_LSB) - 1);
		r = alu_row(exec_isa_pkg::ALU_COPYA, v, 32'd0, v);
		r.write_cr = 1'b1;
		r.cr_sel = exec_state_pkg::CR_VBASE;
		r.chk_vb = 1'b1;
		r.exp_vb = v[XLEN-1:`EXEC_VEC_LSB];
		rows.push_back(r);
		rows.push_back(alu_row(exec_isa_pkg::ALU_GCR, 32'd0, 32'd0, vbase_full));

		// caches and interrupts on with z set
		r = blank_row();
		r.dbg_we = 1'b1;
		r.dbg_val = 32'h71;
		r.chk_dbg = 1'b1;
		r.exp_dbg = 32'h71;
		r.chk_irq = 1'b1;
		r.exp_irq = 1'b1;
		rows.push_back(r);
		f = $urandom();
		r = blank_row();
		r.exc = 1'b1;
		r.fault = f;
		r.dbg_sel = exec_state_pkg::CR_SAVED_PSR;
		r.chk_dbg = 1'b1;
		r.exp_dbg = 32'h71;
		r.chk_irq = 1'b1;
		r.exp_irq = 1'b0;
		rows.push_back(r);
		r = blank_row();
		r.dbg_sel = exec_state_pkg::CR_FAULT_ADDR;
		r.chk_dbg = 1'b1;
		r.exp_dbg = f;
		rows.push_back(r);
		r = blank_row();
		r.chk_dbg = 1'b1;
		r.exp_dbg = 32'h61;
		rows.push_back(r);
		r = alu_row(exec_isa_pkg::ALU_RFE, 32'd0, 32'd0, f);
		r.cls = exec_isa_pkg::CLASS_MISC;
		r.is_rfe = 1'b1;
		r.exp_br = 1'b1;
		r.chk_dbg = 1'b1;
		r.exp_dbg = 32'h71;
		r.chk_irq = 1'b1;
		r.exp_irq = 1'b1;
		rows.push_back(r);

		// new PSR value for SWI to save
		r = blank_row();
		r.dbg_we = 1'b1;
		r.dbg_val = 32'h35;
		r.chk_dbg = 1'b1;
		r.exp_dbg = 32'h35;
		rows.push_back(r);
		r = alu_row(exec_isa_pkg::ALU_SWI, 32'd0, 32'd0, vbase_full + `EXEC_SWI_OFFSET);
		r.cls = exec_isa_pkg::CLASS_MISC;
		r.is_swi = 1'b1;
		r.pc4 = $urandom() & ~32'h3;
		r.exp_br = 1'b1;
		r.dbg_sel = exec_state_pkg::CR_SAVED_PSR;
		r.chk_dbg = 1'b1;
		r.exp_dbg = 32'h35;
		r.chk_irq = 1'b1;
		r.exp_irq = 1'b0;
		rows.push_back(r);
		a = r.pc4;
		r = blank_row();
		r.dbg_sel = exec_state_pkg::CR_FAULT_ADDR;
		r.chk_dbg = 1'b1;
		r.exp_dbg = a;
		rows.push_back(r);

		// store address from ra plus immediate
		r = alu_row(exec_isa_pkg::ALU_ADD, $urandom(), $urandom(), 32'd0);
		r.cls = exec_isa_pkg::CLASS_LDST;
		r.upd_rd = 1'b0;
		r.op2_rb = 1'b0;
		r.imm = $urandom();
		r.mem_store = 1'b1;
		r.exp_alu = r.ra + r.imm;
		r.exp_wr = r.imm;
		r.chk_mem = 1'b1;
		r.exp_mar = r.ra + r.imm;
		r.exp_mdr = r.rb;
		rows.push_back(r);
		r = alu_row(exec_isa_pkg::ALU_ADD, $urandom(), $urandom(), 32'd0);
		r.cls = exec_isa_pkg::CLASS_LDST;
		r.op2_rb = 1'b0;
		r.imm = $urandom();
		r.mem_load = 1'b1;
		r.mem_width = 2'd0;
		r.exp_alu = r.ra + r.imm;
		r.exp_wr = r.exp_alu;
		r.chk_mem = 1'b1;
		r.exp_mar = r.ra + r.imm;
		r.exp_mdr = r.rb;
		rows.push_back(r);
		r = branch_row(exec_isa_pkg::CC_ALWAYS, 1'b1);
		r.is_call = 1'b1;
		r.upd_rd = 1'b1;
		r.exp_wr = r.pc4;
		rows.push_back(r);
	endtask

	task automatic drive_row(input row_t r);
		i_valid = r.valid;
		i_ra = r.ra;
		i_rb = r.rb;
		i_imm = r.imm;
		i_pc_plus_4 = r.pc4;
		i_rd_sel = r.rd_sel;
		i_update_rd = r.upd_rd;
		i_alu_opc = r.opc;
		i_op1_sel = r.op1_sel;
		i_op2_rb = r.op2_rb;
		i_mem_load = r.mem_load;
		i_mem_store = r.mem_store;
		i_mem_width = r.mem_width;
		i_branch_cc = r.cc;
		i_instr_class = r.cls;
		i_is_call = r.is_call;
		i_update_carry = r.upd_carry;
		i_update_flags = r.upd_flags;
		i_cr_sel = r.cr_sel;
		i_write_cr = r.write_cr;
		i_is_swi = r.is_swi;
		i_is_rfe = r.is_rfe;
		i_exception_start = r.exc;
		i_fault_address = r.fault;
		i_dbg_cr_sel = r.dbg_sel;
		i_dbg_cr_wr_en = r.dbg_we;
		i_dbg_cr_wr_val = r.dbg_val;
	endtask

	task automatic check_row(input row_t r, input int idx);
		assert (o_valid === r.valid)
			else report_mismatch($sformatf("row %0d o_valid %b, expected %b", idx, o_valid, r.valid));
		assert (o_branch_taken === r.exp_br)
			else report_mismatch($sformatf("row %0d o_branch_taken %b, expected %b",
				idx, o_branch_taken, r.exp_br));
		assert (o_wr_result === r.upd_rd)
			else report_mismatch($sformatf("row %0d o_wr_result %b, expected %b",
				idx, o_wr_result, r.upd_rd));
		assert (o_mem_load === r.mem_load && o_mem_store === r.mem_store)
			else report_mismatch($sformatf("row %0d o_mem_load %b o_mem_store %b, expected %b %b",
				idx, o_mem_load, o_mem_store, r.mem_load, r.mem_store));
		if (r.chk_alu) begin
			assert (o_alu_out === r.exp_alu)
				else report_mismatch($sformatf("row %0d o_alu_out %h, expected %h",
					idx, o_alu_out, r.exp_alu));
			assert (o_wr_val === r.exp_wr)
				else report_mismatch($sformatf("row %0d o_wr_val %h, expected %h",
					idx, o_wr_val, r.exp_wr));
			assert (o_rd_sel === r.rd_sel)
				else report_mismatch($sformatf("row %0d o_rd_sel %h, expected %h",
					idx, o_rd_sel, r.rd_sel));
		end
		if (r.chk_dbg)
			assert (o_dbg_cr_val === r.exp_dbg)
				else report_mismatch($sformatf("row %0d o_dbg_cr_val %h, expected %h",
					idx, o_dbg_cr_val, r.exp_dbg));
		if (r.chk_irq)
			assert (o_irqs_enabled === r.exp_irq)
				else report_mismatch($sformatf("row %0d o_irqs_enabled %b, expected %b",
					idx, o_irqs_enabled, r.exp_irq));
		if (r.chk_vb)
			assert (o_vector_base === r.exp_vb)
				else report_mismatch($sformatf("row %0d o_vector_base %h, expected %h",
					idx, o_vector_base, r.exp_vb));
		if (r.chk_mem) begin
			assert (o_mem_width === r.mem_width)
				else report_mismatch($sformatf("row %0d o_mem_width %h, expected %h",
					idx, o_mem_width, r.mem_width));
			assert (o_mar === r.exp_mar && o_mdr === r.exp_mdr)
				else report_mismatch($sformatf("row %0d o_mar %h o_mdr %h, expected %h %h",
					idx, o_mar, o_mdr, r.exp_mar, r.exp_mdr));
		end
	endtask

	initial begin
		int unsigned seed_ret;
		seed_ret = $urandom(32'he5aa);
		clk = 1'b0;
		rst = 1'b1;
		cycles = 0;
		cycle_limit = 0;
		drive_row(blank_row());
		build_table();
		cycle_limit = rows.size() + 40;

		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		assert ({o_valid, o_branch_taken, o_wr_result, o_mem_load, o_mem_store} === 5'b0)
			else report_mismatch("strobes not cleared by reset");
		assert (o_dbg_cr_val === '0)
			else report_mismatch($sformatf("PSR after reset %h, expected 0", o_dbg_cr_val));

		for (int i = 0; i < rows.size(); i++) begin
			drive_row(rows[i]);
			@(negedge clk);
			check_row(rows[i], i);
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

// File: include/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// data path width
`define EXEC_XLEN 32

// control register slots, 5 to 7 read as zero
`define EXEC_NUM_CR 8

// vector base is 64-byte aligned
`define EXEC_VEC_LSB 6

// software interrupt entry within the vector table
`define EXEC_SWI_OFFSET 8

`endif

// File: verilog/exec_alu.sv
`include "exec_cfg.svh"

module exec_alu (
	input  logic [`EXEC_XLEN-1:0]               i_op1,
	input  logic [`EXEC_XLEN-1:0]               i_op2,
	input  exec_isa_pkg::alu_opc_e              i_opc,
	input  exec_state_pkg::psr_t                i_psr,
	input  logic [`EXEC_XLEN-1:0]               i_cr_val,
	input  logic [`EXEC_XLEN-`EXEC_VEC_LSB-1:0] i_vector_base,
	exec_alu_if.alu                             res
);

	localparam int XLEN = `EXEC_XLEN;
	localparam int VEC_LSB = `EXEC_VEC_LSB;
	localparam int SHW = $clog2(XLEN);
	localparam logic [VEC_LSB-1:0] SWI_OFF = `EXEC_SWI_OFFSET;

	logic [XLEN:0]   wide;
	logic [XLEN-1:0] q;
	logic            c;
	logic            n;
	logic            o;
	logic [SHW-1:0]  sh;
	logic [XLEN:0]   cin;

	assign sh = i_op2[SHW-1:0];
	assign cin = {{XLEN{1'b0}}, i_psr.c};

	always_comb begin
		wide = '0;
		q = '0;
		c = 1'b0;
		n = 1'b0;
		o = 1'b0;

		case (i_opc)
		exec_isa_pkg::ALU_ADD:   wide = {1'b0, i_op1} + {1'b0, i_op2};
		exec_isa_pkg::ALU_ADDC:  wide = {1'b0, i_op1} + {1'b0, i_op2} + cin;
		exec_isa_pkg::ALU_SUB:   wide = {1'b0, i_op1} - {1'b0, i_op2};
		exec_isa_pkg::ALU_SUBC:  wide = {1'b0, i_op1} - {1'b0, i_op2} - cin;
		exec_isa_pkg::ALU_MUL:   wide = {1'b0, i_op1} * {1'b0, i_op2};
		exec_isa_pkg::ALU_LSL:   wide = {1'b0, i_op1} << sh;
		exec_isa_pkg::ALU_LSR:   wide[XLEN-1:0] = i_op1 >> sh;
		exec_isa_pkg::ALU_ASR:   wide[XLEN-1:0] = $signed(i_op1) >>> sh;
		exec_isa_pkg::ALU_AND:   wide[XLEN-1:0] = i_op1 & i_op2;
		exec_isa_pkg::ALU_OR:    wide[XLEN-1:0] = i_op1 | i_op2;
		exec_isa_pkg::ALU_XOR:   wide[XLEN-1:0] = i_op1 ^ i_op2;
		exec_isa_pkg::ALU_BIC:   wide[XLEN-1:0] = i_op1 & ~(XLEN'(1) << sh);
		exec_isa_pkg::ALU_BST:   wide[XLEN-1:0] = i_op1 | (XLEN'(1) << sh);
		exec_isa_pkg::ALU_COPYA: wide[XLEN-1:0] = i_op1;
		exec_isa_pkg::ALU_COPYB: wide[XLEN-1:0] = i_op2;
		exec_isa_pkg::ALU_CMP:   wide = {1'b0, i_op1} - {1'b0, i_op2};
		exec_isa_pkg::ALU_MOVHI: wide[XLEN-1:0] = i_op1 | {16'b0, i_op2[15:0]};
		exec_isa_pkg::ALU_GCR:   wide[XLEN-1:0] = i_cr_val;
		exec_isa_pkg::ALU_SWI:   wide[XLEN-1:0] = {i_vector_base, SWI_OFF};
		// cr index is forced to the fault address by the stage
		exec_isa_pkg::ALU_RFE:   wide[XLEN-1:0] = i_cr_val;
		default:                 wide = '0;
		endcase

		q = wide[XLEN-1:0];

		case (i_opc)
		exec_isa_pkg::ALU_ADD,
		exec_isa_pkg::ALU_ADDC,
		exec_isa_pkg::ALU_SUB,
		exec_isa_pkg::ALU_SUBC,
		exec_isa_pkg::ALU_MUL,
		exec_isa_pkg::ALU_LSL: c = wide[XLEN];
		exec_isa_pkg::ALU_CMP: begin
			// c set means no borrow, op1 >= op2 unsigned
			c = ~wide[XLEN];
			n = q[XLEN-1];
			o = (i_op1[XLEN-1] ^ i_op2[XLEN-1]) && (q[XLEN-1] == i_op2[XLEN-1]);
		end
		default: c = 1'b0;
		endcase
	end

	assign res.q = q;
	assign res.c = c;
	assign res.n = n;
	assign res.o = o;
	assign res.z = (i_op1 == i_op2);

endmodule

// File: verilog/exec_alu_if.sv
`include "exec_cfg.svh"

interface exec_alu_if;

	logic [`EXEC_XLEN-1:0] q;
	// flag candidates, applied only when the instruction asks
	logic c;
	logic z;
	logic n;
	logic o;

	modport alu (
		output q, c, z, n, o
	);

	modport sink (
		input q, c, z, n, o
	);

endinterface

// File: verilog/exec_branch_cond.sv
module exec_branch_cond (
	input  exec_isa_pkg::branch_cc_e i_cc,
	input  exec_state_pkg::psr_t     i_psr,
	output logic                     o_cond_met
);

	logic signed_lt;

	// n differs from o when a signed compare found op1 < op2
	assign signed_lt = i_psr.n != i_psr.o;

	always_comb begin
		case (i_cc)
		exec_isa_pkg::CC_NE:     o_cond_met = !i_psr.z;
		exec_isa_pkg::CC_EQ:     o_cond_met = i_psr.z;
		exec_isa_pkg::CC_GT:     o_cond_met = i_psr.c && !i_psr.z;
		exec_isa_pkg::CC_LT:     o_cond_met = !i_psr.c;
		exec_isa_pkg::CC_GTS:    o_cond_met = !i_psr.z && !signed_lt;
		exec_isa_pkg::CC_LTS:    o_cond_met = signed_lt;
		exec_isa_pkg::CC_ALWAYS: o_cond_met = 1'b1;
		exec_isa_pkg::CC_GTE:    o_cond_met = i_psr.c;
		exec_isa_pkg::CC_GTES:   o_cond_met = !signed_lt;
		exec_isa_pkg::CC_LTE:    o_cond_met = !i_psr.c || i_psr.z;
		exec_isa_pkg::CC_LTES:   o_cond_met = signed_lt || i_psr.z;
		default:                 o_cond_met = 1'b0;
		endcase
	end

endmodule

// File: verilog/exec_ctrl_regs.sv
`include "exec_cfg.svh"

module exec_ctrl_regs (
	input  logic                                clk,
	input  logic                                rst,
	input  exec_state_pkg::cr_idx_e             i_cr_sel,
	input  logic                                i_write_cr,
	input  logic [`EXEC_XLEN-1:0]               i_wr_data,
	input  exec_state_pkg::cr_idx_e             i_dbg_sel,
	input  logic                                i_dbg_wr_en,
	input  logic [`EXEC_XLEN-1:0]               i_dbg_wr_data,
	input  logic                                i_update_flags,
	input  logic                                i_update_carry,
	exec_alu_if.sink                            flags,
	input  logic                                i_exception_start,
	input  logic [`EXEC_XLEN-1:0]               i_fault_address,
	input  logic                                i_is_swi,
	input  logic                                i_is_rfe,
	input  logic [`EXEC_XLEN-1:0]               i_return_addr,
	output exec_state_pkg::psr_t                o_psr,
	output logic [`EXEC_XLEN-1:0]               o_cr_val,
	output logic [`EXEC_XLEN-1:0]               o_dbg_val,
	output logic [`EXEC_XLEN-`EXEC_VEC_LSB-1:0] o_vector_base
);

	localparam int XLEN = `EXEC_XLEN;
	localparam int VEC_LSB = `EXEC_VEC_LSB;
	localparam int NUM_CR = `EXEC_NUM_CR;

	logic [XLEN-VEC_LSB-1:0] vbase;
	exec_state_pkg::psr_t    psr;
	exec_state_pkg::psr_t    psr_next;
	exec_state_pkg::psr_t    saved_psr;
	logic [XLEN-1:0]         fault_addr;
	logic [XLEN-1:0]         dfault_addr;
	logic [NUM_CR-1:0]       dbg_wr;
	logic [NUM_CR-1:0]       ins_wr;
	logic [XLEN-1:0]         cr_view [NUM_CR];
	logic                    exc_entry;

	// one-hot write strobes per register
	assign dbg_wr = i_dbg_wr_en ? (NUM_CR'(1) << i_dbg_sel) : '0;
	assign ins_wr = i_write_cr ? (NUM_CR'(1) << i_cr_sel) : '0;
	assign exc_entry = i_exception_start || i_is_swi;

	// later assignments take priority
	always_comb begin
		psr_next = psr;
		if (i_update_flags) begin
			psr_next.z = flags.z;
			psr_next.n = flags.n;
			psr_next.o = flags.o;
		end
		if (i_update_carry)
			psr_next.c = flags.c;
		if (ins_wr[exec_state_pkg::CR_PSR])
			psr_next = exec_state_pkg::psr_t'(i_wr_data[7:0]);
		if (exc_entry)
			psr_next.irqs_en = 1'b0;
		if (i_is_rfe)
			psr_next = saved_psr;
		if (dbg_wr[exec_state_pkg::CR_PSR])
			psr_next = exec_state_pkg::psr_t'(i_dbg_wr_data[7:0]);
		psr_next.reserved = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vbase <= '0;
			psr <= '0;
			saved_psr <= '0;
			fault_addr <= '0;
			dfault_addr <= '0;
		end else begin
			psr <= psr_next;

			if (dbg_wr[exec_state_pkg::CR_VBASE])
				vbase <= i_dbg_wr_data[XLEN-1:VEC_LSB];
			else if (ins_wr[exec_state_pkg::CR_VBASE])
				vbase <= i_wr_data[XLEN-1:VEC_LSB];

			if (dbg_wr[exec_state_pkg::CR_SAVED_PSR])
				saved_psr <= exec_state_pkg::psr_t'(i_dbg_wr_data[7:0]);
			else if (exc_entry)
				saved_psr <= psr;
			else if (ins_wr[exec_state_pkg::CR_SAVED_PSR])
				saved_psr <= exec_state_pkg::psr_t'(i_wr_data[7:0]);

			if (dbg_wr[exec_state_pkg::CR_FAULT_ADDR])
				fault_addr <= i_dbg_wr_data;
			else if (i_exception_start)
				fault_addr <= i_fault_address;
			else if (i_is_swi)
				fault_addr <= i_return_addr;
			else if (ins_wr[exec_state_pkg::CR_FAULT_ADDR])
				fault_addr <= i_wr_data;

			if (dbg_wr[exec_state_pkg::CR_DFAULT_ADDR])
				dfault_addr <= i_dbg_wr_data;
			else if (ins_wr[exec_state_pkg::CR_DFAULT_ADDR])
				dfault_addr <= i_wr_data;
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_CR; i++)
			cr_view[i] = '0;
		cr_view[exec_state_pkg::CR_VBASE] = {vbase, {VEC_LSB{1'b0}}};
		cr_view[exec_state_pkg::CR_PSR] = {{(XLEN-8){1'b0}}, psr};
		cr_view[exec_state_pkg::CR_SAVED_PSR] = {{(XLEN-8){1'b0}}, saved_psr};
		cr_view[exec_state_pkg::CR_FAULT_ADDR] = fault_addr;
		cr_view[exec_state_pkg::CR_DFAULT_ADDR] = dfault_addr;
	end

	assign o_psr = psr;
	assign o_cr_val = cr_view[i_cr_sel];
	assign o_dbg_val = cr_view[i_dbg_sel];
	assign o_vector_base = vbase;

endmodule

// File: verilog/exec_isa_pkg.sv
package exec_isa_pkg;

	// alu operations, unlisted codes give zero
	typedef enum logic [4:0] {
		ALU_ADD,
		ALU_ADDC,
		ALU_SUB,
		ALU_SUBC,
		ALU_MUL,
		ALU_LSL,
		ALU_LSR,
		ALU_ASR,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_BIC,
		ALU_BST,
		ALU_COPYA,
		ALU_COPYB,
		ALU_CMP,
		ALU_MOVHI,
		ALU_GCR,
		ALU_SWI,
		ALU_RFE
	} alu_opc_e;

	typedef enum logic [3:0] {
		CC_NEVER  = 4'd0,
		CC_NE     = 4'd1,
		CC_EQ     = 4'd2,
		CC_GT     = 4'd3,
		CC_LT     = 4'd4,
		CC_GTS    = 4'd5,
		CC_LTS    = 4'd6,
		CC_ALWAYS = 4'd7,
		CC_GTE    = 4'd8,
		CC_GTES   = 4'd9,
		CC_LTE    = 4'd10,
		CC_LTES   = 4'd11
	} branch_cc_e;

	typedef enum logic [1:0] {CLASS_ARITH, CLASS_BRANCH, CLASS_LDST, CLASS_MISC} instr_class_e;

	typedef enum logic [1:0] {OP1_RA, OP1_RB, OP1_PC} op1_sel_e;

endpackage

// File: verilog/exec_stage.sv
`include "exec_cfg.svh"

module exec_stage (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                i_valid,
	input  logic [`EXEC_XLEN-1:0]               i_ra,
	input  logic [`EXEC_XLEN-1:0]               i_rb,
	input  logic [`EXEC_XLEN-1:0]               i_imm,
	input  logic [`EXEC_XLEN-1:0]               i_pc_plus_4,
	input  logic [3:0]                          i_rd_sel,
	input  logic                                i_update_rd,
	input  exec_isa_pkg::alu_opc_e              i_alu_opc,
	input  exec_isa_pkg::op1_sel_e              i_op1_sel,
	input  logic                                i_op2_rb,
	input  logic                                i_mem_load,
	input  logic                                i_mem_store,
	input  logic [1:0]                          i_mem_width,
	input  exec_isa_pkg::branch_cc_e            i_branch_cc,
	input  exec_isa_pkg::instr_class_e          i_instr_class,
	input  logic                                i_is_call,
	input  logic                                i_update_carry,
	input  logic                                i_update_flags,
	input  exec_state_pkg::cr_idx_e             i_cr_sel,
	input  logic                                i_write_cr,
	input  logic                                i_is_swi,
	input  logic                                i_is_rfe,
	input  logic                                i_exception_start,
	input  logic [`EXEC_XLEN-1:0]               i_fault_address,
	input  exec_state_pkg::cr_idx_e             i_dbg_cr_sel,
	input  logic                                i_dbg_cr_wr_en,
	input  logic [`EXEC_XLEN-1:0]               i_dbg_cr_wr_val,
	output logic                                o_valid,
	output logic                                o_branch_taken,
	output logic [`EXEC_XLEN-1:0]               o_alu_out,
	output logic [`EXEC_XLEN-1:0]               o_wr_val,
	output logic                                o_wr_result,
	output logic [3:0]                          o_rd_sel,
	output logic                                o_mem_load,
	output logic                                o_mem_store,
	output logic [1:0]                          o_mem_width,
	output logic [`EXEC_XLEN-1:0]               o_mar,
	output logic [`EXEC_XLEN-1:0]               o_mdr,
	output logic [`EXEC_XLEN-1:0]               o_dbg_cr_val,
	output logic [`EXEC_XLEN-`EXEC_VEC_LSB-1:0] o_vector_base,
	output logic                                o_irqs_enabled
);

	localparam int XLEN = `EXEC_XLEN;

	logic [XLEN-1:0]               op1;
	logic [XLEN-1:0]               op2;
	logic [XLEN-1:0]               cr_val;
	exec_state_pkg::psr_t          psr;
	exec_state_pkg::cr_idx_e       cr_sel;
	logic                          cond_met;
	logic                          v_update_flags;
	logic                          v_update_carry;
	logic                          v_write_cr;
	logic                          v_is_rfe;
	logic                          v_is_swi;
	logic                          v_branch;

	exec_alu_if alu_res ();

	always_comb begin
		case (i_op1_sel)
		exec_isa_pkg::OP1_RA: op1 = i_ra;
		exec_isa_pkg::OP1_RB: op1 = i_rb;
		default:              op1 = i_pc_plus_4;
		endcase
	end

	assign op2 = i_op2_rb ? i_rb : i_imm;

	// RFE returns to the saved fault address
	assign cr_sel = (i_alu_opc == exec_isa_pkg::ALU_RFE) ? exec_state_pkg::CR_FAULT_ADDR : i_cr_sel;

	// state changes only for a valid instruction
	assign v_update_flags = i_valid && i_update_flags;
	assign v_update_carry = i_valid && i_update_carry;
	assign v_write_cr = i_valid && i_write_cr;
	assign v_is_rfe = i_valid && i_is_rfe;
	assign v_is_swi = i_valid && i_is_swi;
	assign v_branch = i_valid && (i_instr_class == exec_isa_pkg::CLASS_BRANCH);

	exec_alu u_alu (
		.i_op1         (op1),
		.i_op2         (op2),
		.i_opc         (i_alu_opc),
		.i_psr         (psr),
		.i_cr_val      (cr_val),
		.i_vector_base (o_vector_base),
		.res           (alu_res)
	);

	exec_branch_cond u_branch_cond (
		.i_cc       (i_branch_cc),
		.i_psr      (psr),
		.o_cond_met (cond_met)
	);

	exec_ctrl_regs u_ctrl_regs (
		.clk               (clk),
		.rst               (rst),
		.i_cr_sel          (cr_sel),
		.i_write_cr        (v_write_cr),
		.i_wr_data         (i_ra),
		.i_dbg_sel         (i_dbg_cr_sel),
		.i_dbg_wr_en       (i_dbg_cr_wr_en),
		.i_dbg_wr_data     (i_dbg_cr_wr_val),
		.i_update_flags    (v_update_flags),
		.i_update_carry    (v_update_carry),
		.flags             (alu_res),
		.i_exception_start (i_exception_start),
		.i_fault_address   (i_fault_address),
		.i_is_swi          (v_is_swi),
		.i_is_rfe          (v_is_rfe),
		.i_return_addr     (i_pc_plus_4),
		.o_psr             (psr),
		.o_cr_val          (cr_val),
		.o_dbg_val         (o_dbg_cr_val),
		.o_vector_base     (o_vector_base)
	);

	assign o_irqs_enabled = psr.irqs_en;

	always_ff @(posedge clk) begin
		if (rst) begin
			o_valid <= 1'b0;
			o_branch_taken <= 1'b0;
			o_wr_result <= 1'b0;
			o_mem_load <= 1'b0;
			o_mem_store <= 1'b0;
		end else begin
			o_valid <= i_valid;
			o_branch_taken <= (v_branch && cond_met) || v_is_swi || v_is_rfe;
			o_wr_result <= i_valid && i_update_rd;
			o_mem_load <= i_valid && i_mem_load;
			o_mem_store <= i_valid && i_mem_store;
		end
	end

	always_ff @(posedge clk) begin
		o_alu_out <= alu_res.q;
		o_rd_sel <= i_rd_sel;
		o_wr_val <= i_is_call ? i_pc_plus_4 : i_mem_store ? op2 : alu_res.q;
		if (i_mem_load || i_mem_store) begin
			o_mem_width <= i_mem_width;
			o_mar <= alu_res.q;
			o_mdr <= i_rb;
		end
	end

endmodule

// File: verilog/exec_state_pkg.sv
package exec_state_pkg;

	// control register numbers
	typedef enum logic [2:0] {
		CR_VBASE       = 3'd0,
		CR_PSR         = 3'd1,
		CR_SAVED_PSR   = 3'd2,
		CR_FAULT_ADDR  = 3'd3,
		CR_DFAULT_ADDR = 3'd4
	} cr_idx_e;

	// low byte of CR1 and CR2
	typedef struct packed {
		logic reserved;
		logic icache_en;
		logic dcache_en;
		logic irqs_en;
		logic n;
		logic o;
		logic c;
		logic z;
	} psr_t;

endpackage
